//--- list.f
+incdir+testbench
design/lsu_pkg.sv
design/lsu_arb.sv
design/lsu_dtlb.sv
design/ls_pipe.sv
design/lsu_top.sv
testbench/wb_mem_model.sv
testbench/lsu_tb.sv

//--- testbench/lsu_tb_tasks.svh
// Request, ack, refill and scoreboard helpers and the directed LSU tests
`ifndef LSU_TB_TASKS_SVH
`define LSU_TB_TASKS_SVH

////////////////////////////////////////
// Helpers
////////////////////////////////////////

function automatic void check_val(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
    check_cnt++;
    assert (got === exp) else begin
        error_cnt++;
        $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
endfunction

// Physical page times 4096 plus the page offset
function automatic logic [31:0] translate(input logic [31:0] va);
    logic [31:0] pa;
    pa = 'x;
    foreach (map_vpn[i]) begin
        if (map_vpn[i] == va[31:page_bits]) begin
            pa = 32'(map_ppn[i]) * 32'd4096 + 32'(va[page_bits-1:0]);
        end
    end
    return pa;
endfunction

function automatic void check_ack(input lsu_ack_t a, input logic [31:0] va,
                                  input logic [31:0] rdata, input logic miss, input logic err);
    check_val("ack.va", a.va, va);
    check_val("ack.rdata", a.rdata, rdata);
    check_val("ack.tlb_miss", a.tlb_miss, miss);
    check_val("ack.bus_err", a.bus_err, err);
endfunction

task automatic poke_word(input logic [31:0] pa, input logic [31:0] data);
    mem_i.mem[pa[9:2]] = data;  // Backdoor write while the bus is idle
    sb_mem[pa[9:2]]    = data;
endtask

task automatic start_req(input lsu_src_e src, input lsu_op_e op, input logic [31:0] addr,
                         input logic [31:0] wdata);
    lsu_req_t r;
    r.op    = op;
    r.src   = src;
    r.addr  = addr;
    r.wdata = wdata;
    case (src)
        src_dptw: begin
            dptw_valid <= 1'b1;
            dptw_req   <= r;
        end
        src_prf: begin
            prf_valid <= 1'b1;
            prf_req   <= r;
        end
        default: begin
            lsq_valid <= 1'b1;
            lsq_req   <= r;
        end
    endcase
endtask

task automatic wait_accept(input lsu_src_e src);
    logic rdy;
    rdy = 1'b0;
    while (!rdy) begin
        @(negedge core_clk);
        case (src)
            src_dptw: rdy = (dptw_ready === 1'b1);
            src_prf:  rdy = (prf_ready === 1'b1);
            default:  rdy = (lsq_ready === 1'b1);
        endcase
        @(posedge core_clk);
    end
    case (src)
        src_dptw: dptw_valid <= 1'b0;
        src_prf:  prf_valid <= 1'b0;
        default:  lsq_valid <= 1'b0;
    endcase
endtask

task automatic send(input lsu_src_e src, input lsu_op_e op, input logic [31:0] addr,
                    input logic [31:0] wdata);
    start_req(src, op, addr, wdata);
    wait_accept(src);
endtask

task automatic get_ack(input lsu_src_e src, output lsu_ack_t a);
    lsu_src_e line;
    while (ack_q.size() == 0) begin
        @(posedge core_clk);
    end
    a    = ack_q.pop_front();
    line = ack_src_q.pop_front();
    check_val("ack valid line", line, src);
    check_val("ack.src", a.src, src);
endtask

task automatic refill_map(input logic [19:0] vpn, input logic [19:0] ppn);
    refill_valid <= 1'b1;
    refill_vpn   <= vpn;
    refill_ppn   <= ppn;
    @(posedge core_clk);
    refill_valid <= 1'b0;
    map_vpn.push_back(vpn);
    map_ppn.push_back(ppn);
endtask

task automatic mmu_respond;
    mmu_resp_valid <= 1'b1;
    @(posedge core_clk);
    mmu_resp_valid <= 1'b0;
endtask

////////////////////////////////////////
// Directed tests
////////////////////////////////////////

task automatic test_ptw_bypass;
    logic [31:0] pa;
    lsu_ack_t    a;
    pa = 32'h0000_3010;
    poke_word(pa, $urandom);
    send(src_dptw, op_ptw_read, pa, 32'h0);
    get_ack(src_dptw, a);
    check_ack(a, pa, sb_mem[pa[9:2]], 1'b0, 1'b0);
endtask

task automatic test_store_load;
    logic [31:0] va;
    logic [31:0] pa;
    logic [31:0] data;
    lsu_ack_t    a;
    va   = {vpn_a, 12'h104};
    data = $urandom;
    refill_map(vpn_a, ppn_a);
    pa = translate(va);
    send(src_lsq, op_store, va, data);
    get_ack(src_lsq, a);
    check_ack(a, va, 32'h0, 1'b0, 1'b0);
    check_val("store wb_adr", last_wr_adr, pa);
    sb_mem[pa[9:2]] = data;
    send(src_lsq, op_load, va, 32'h0);
    get_ack(src_lsq, a);
    check_ack(a, va, sb_mem[pa[9:2]], 1'b0, 1'b0);
    check_val("mem_i.mem", mem_i.mem[pa[9:2]], data);
endtask

task automatic test_tlb_miss;
    logic [31:0] va;
    logic [31:0] pa;
    logic [31:0] va_p;
    int unsigned mmu0;
    int unsigned rdy0;
    lsu_ack_t    a;
    va   = {vpn_b, 12'h208};
    va_p = {vpn_a, 12'h300};
    pa   = 32'(ppn_b) * 32'd4096 + 32'h208;
    poke_word(pa, $urandom);
    mmu0 = mmu_req_cnt;
    send(src_lsq, op_load, va, 32'h0);
    get_ack(src_lsq, a);
    check_ack(a, va, 32'h0, 1'b1, 1'b0);
    check_val("mmu_req_valid pulses", mmu_req_cnt - mmu0, 1);
    check_val("mmu_va", mmu_va_seen, va);
    rdy0 = prf_ready_cnt;
    start_req(src_prf, op_prefetch, va_p, 32'h0);  // Held while the miss is open
    send(src_dptw, op_ptw_read, pa, 32'h0);
    get_ack(src_dptw, a);
    check_ack(a, pa, sb_mem[pa[9:2]], 1'b0, 1'b0);
    repeat (3) @(posedge core_clk);
    check_val("prf_ready during miss", prf_ready_cnt - rdy0, 0);
    refill_map(vpn_b, ppn_b);
    mmu_respond();
    wait_accept(src_prf);
    get_ack(src_prf, a);
    check_ack(a, va_p, 32'h0, 1'b0, 1'b0);
    send(src_lsq, op_load, va, 32'h0);
    get_ack(src_lsq, a);
    check_ack(a, va, sb_mem[pa[9:2]], 1'b0, 1'b0);
    check_val("mmu_req_valid pulses", mmu_req_cnt - mmu0, 1);
endtask

task automatic test_priority;
    logic [31:0] pa_d;
    logic [31:0] va_p;
    logic [31:0] va_l;
    lsu_ack_t    a;
    pa_d = 32'h0000_3010;
    va_p = {vpn_a, 12'h400};
    va_l = {vpn_a, 12'h104};
    start_req(src_lsq, op_load, va_l, 32'h0);
    start_req(src_prf, op_prefetch, va_p, 32'h0);
    start_req(src_dptw, op_ptw_read, pa_d, 32'h0);
    wait_accept(src_dptw);
    wait_accept(src_prf);
    wait_accept(src_lsq);
    get_ack(src_dptw, a);
    check_ack(a, pa_d, sb_mem[pa_d[9:2]], 1'b0, 1'b0);
    get_ack(src_prf, a);
    check_ack(a, va_p, 32'h0, 1'b0, 1'b0);
    get_ack(src_lsq, a);
    check_ack(a, va_l, sb_mem[translate(va_l) >> 2 & 32'hff], 1'b0, 1'b0);
    repeat (4) @(posedge core_clk);
    check_val("extra acks", ack_q.size(), 0);
endtask

task automatic test_prefetch_bus_err;
    logic [31:0] va_p;
    logic [31:0] va_e;
    int unsigned cyc0;
    lsu_ack_t    a;
    va_p = {vpn_a, 12'h500};
    va_e = {vpn_a, 12'h7f0};
    cyc0 = wb_cyc_cnt;
    send(src_prf, op_prefetch, va_p, 32'h0);
    get_ack(src_prf, a);
    check_ack(a, va_p, 32'h0, 1'b0, 1'b0);
    check_val("wb_cyc cycles in prefetch", wb_cyc_cnt - cyc0, 0);
    send(src_lsq, op_load, va_e, 32'h0);
    get_ack(src_lsq, a);
    check_val("ack.va", a.va, va_e);
    check_val("ack.tlb_miss", a.tlb_miss, 1'b0);
    check_val("ack.bus_err", a.bus_err, 1'b1);
endtask

`endif

//--- testbench/lsu_tb.sv
// LSU testbench top with clock, reset, DUT, memory model, ack monitor, timeout and report
`timescale 1ns/10ps

module lsu_tb;
    import lsu_pkg::*;

    localparam int          timeout_cycles = 2000;
    localparam logic [31:0] rand_seed      = 32'he4b07241;
    localparam logic [19:0] vpn_a          = 20'h40001;
    localparam logic [19:0] ppn_a          = 20'h00012;
    localparam logic [19:0] vpn_b          = 20'h40002;
    localparam logic [19:0] ppn_b          = 20'h00034;
    localparam logic [31:0] err_pa         = {ppn_a, 12'h7f0};  // Slave answers wb_err

    logic        core_clk = 1'b0;
    logic        core_reset_n;
    logic        dptw_valid, prf_valid, lsq_valid;
    lsu_req_t    dptw_req, prf_req, lsq_req;
    logic        dptw_ready, prf_ready, lsq_ready;
    lsu_ack_t    ack;
    logic        dptw_ack_valid, prf_ack_valid, lsq_ack_valid;
    logic        mmu_req_valid;
    logic [31:0] mmu_va;
    logic        mmu_resp_valid;
    logic        refill_valid;
    logic [19:0] refill_vpn, refill_ppn;
    logic        wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
    logic [31:0] wb_adr, wb_dat_o, wb_dat_i;

    logic [31:0] sb_mem [256];
    logic [19:0] map_vpn [$];
    logic [19:0] map_ppn [$];
    lsu_ack_t    ack_q [$];
    lsu_src_e    ack_src_q [$];
    int unsigned mmu_req_cnt = 0;
    int unsigned prf_ready_cnt = 0;
    int unsigned wb_cyc_cnt = 0;
    int unsigned cycle_cnt = 0;
    int unsigned check_cnt = 0;
    int unsigned error_cnt = 0;
    logic [31:0] mmu_va_seen = '0;
    logic [31:0] last_wr_adr = '0;

    `include "lsu_tb_tasks.svh"

    always #10 core_clk = ~core_clk;

    lsu_top #(.valen(32), .palen(32), .tlb_entries(4)) lsu_top_i (
        .core_clk, .core_reset_n,
        .dptw_valid, .dptw_req, .dptw_ready, .prf_valid, .prf_req, .prf_ready,
        .lsq_valid, .lsq_req, .lsq_ready,
        .ack, .dptw_ack_valid, .prf_ack_valid, .lsq_ack_valid,
        .mmu_req_valid, .mmu_va, .mmu_resp_valid, .refill_valid, .refill_vpn, .refill_ppn,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_o, .wb_dat_i, .wb_ack, .wb_err
    );

    wb_mem_model #(.err_adr(err_pa)) mem_i (
        .core_clk, .core_reset_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr,
        .wb_dat_w (wb_dat_o),
        .wb_dat_r (wb_dat_i),
        .wb_ack, .wb_err
    );

    ////////////////////////////////////////
    // Monitor, sampled mid-cycle
    ////////////////////////////////////////

    always @(negedge core_clk) begin
        if (core_reset_n) begin
            assert ($countones({dptw_ack_valid, prf_ack_valid, lsq_ack_valid}) <= 1) else begin
                error_cnt++;
                $display("Error at %0t: more than one ack valid in one cycle", $time);
            end
            if (dptw_ack_valid || prf_ack_valid || lsq_ack_valid) begin
                ack_q.push_back(ack);
                ack_src_q.push_back(dptw_ack_valid ? src_dptw : (prf_ack_valid ? src_prf : src_lsq));
            end
            if (mmu_req_valid) begin
                mmu_req_cnt++;
                mmu_va_seen = mmu_va;
            end
            if (prf_ready) prf_ready_cnt++;
            if (wb_cyc) wb_cyc_cnt++;
            if (wb_cyc && wb_we) last_wr_adr = wb_adr;
        end
    end

    always @(posedge core_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == timeout_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        void'($urandom(rand_seed));
        core_reset_n   = 1'b0;
        dptw_valid     = 1'b0;
        prf_valid      = 1'b0;
        lsq_valid      = 1'b0;
        dptw_req       = '0;
        prf_req        = '0;
        lsq_req        = '0;
        mmu_resp_valid = 1'b0;
        refill_valid   = 1'b0;
        refill_vpn     = '0;
        refill_ppn     = '0;
        repeat (4) @(posedge core_clk);
        @(negedge core_clk);
        check_val("outputs in reset", {dptw_ready, prf_ready, lsq_ready, dptw_ack_valid,
                  prf_ack_valid, lsq_ack_valid, mmu_req_valid, wb_cyc, wb_stb}, '0);
        @(posedge core_clk);
        core_reset_n <= 1'b1;
        @(posedge core_clk);
        test_ptw_bypass();
        test_store_load();
        test_tlb_miss();
        test_priority();
        test_prefetch_bus_err();
        repeat (2) @(posedge core_clk);
        $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/wb_mem_model.sv
// Wishbone classic slave memory model with 256 words, one-cycle ack and one error address
`timescale 1ns/10ps

module wb_mem_model #(
    parameter logic [31:0] err_adr = 32'hffff_fff0
) (
    input  logic        core_clk,
    input  logic        core_reset_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        wb_err
);
    logic [31:0] mem [256];
    logic        start;
    logic [7:0]  idx;

    assign start = wb_cyc && wb_stb && !wb_ack && !wb_err;
    assign idx   = wb_adr[9:2];  // Upper address bits alias

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'h5a5a_0000 ^ (i << 2);  // Byte address in the low bits
        end
    end

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            wb_ack <= 1'b0;
            wb_err <= 1'b0;
        end else begin
            wb_ack <= start && (wb_adr != err_adr);
            wb_err <= start && (wb_adr == err_adr);
        end
    end

    always @(posedge core_clk) begin
        if (start) begin
            wb_dat_r <= mem[idx];
            if (wb_we && (wb_adr != err_adr)) begin
                mem[idx] <= wb_dat_w;  // No write on a failed cycle
            end
        end
    end

endmodule

//--- design/lsu_top.sv
// LSU front end top level joining arbiter, data TLB and load/store pipe
`timescale 1ns/10ps

module lsu_top #(
    parameter int valen       = 32,
    parameter int palen       = 32,
    parameter int tlb_entries = 4
) (
    input  logic                              core_clk,
    input  logic                              core_reset_n,
    // Requesters
    input  logic                              dptw_valid,
    input  lsu_pkg::lsu_req_t                 dptw_req,
    output logic                              dptw_ready,
    input  logic                              prf_valid,
    input  lsu_pkg::lsu_req_t                 prf_req,
    output logic                              prf_ready,
    input  logic                              lsq_valid,
    input  lsu_pkg::lsu_req_t                 lsq_req,
    output logic                              lsq_ready,
    // Shared ack bus
    output lsu_pkg::lsu_ack_t                 ack,
    output logic                              dptw_ack_valid,
    output logic                              prf_ack_valid,
    output logic                              lsq_ack_valid,
    // MMU and TLB refill
    output logic                              mmu_req_valid,
    output logic [31:0]                       mmu_va,
    input  logic                              mmu_resp_valid,
    input  logic                              refill_valid,
    input  logic [valen-1:lsu_pkg::page_bits] refill_vpn,
    input  logic [palen-1:lsu_pkg::page_bits] refill_ppn,
    // Wishbone
    output logic                              wb_cyc,
    output logic                              wb_stb,
    output logic                              wb_we,
    output logic [palen-1:0]                  wb_adr,
    output logic [31:0]                       wb_dat_o,
    input  logic [31:0]                       wb_dat_i,
    input  logic                              wb_ack,
    input  logic                              wb_err
);
    import lsu_pkg::*;

    logic                     grant_valid;
    lsu_req_t                 grant_req;
    logic                     pipe_ready;
    logic                     pipe_ack_valid;
    logic [valen-1:page_bits] lookup_vpn;
    logic                     tlb_hit;
    logic [palen-1:page_bits] tlb_ppn;

    lsu_arb lsu_arb_i (
        .core_clk, .core_reset_n,
        .dptw_valid, .dptw_req, .dptw_ready,
        .prf_valid, .prf_req, .prf_ready,
        .lsq_valid, .lsq_req, .lsq_ready,
        .grant_valid, .grant_req, .pipe_ready, .pipe_ack_valid,
        .pipe_ack (ack),
        .dptw_ack_valid, .prf_ack_valid, .lsq_ack_valid,
        .mmu_req_valid, .mmu_va, .mmu_resp_valid
    );

    lsu_dtlb #(.valen(valen), .palen(palen), .tlb_entries(tlb_entries)) lsu_dtlb_i (
        .core_clk, .core_reset_n, .lookup_vpn,
        .hit (tlb_hit),
        .ppn (tlb_ppn),
        .refill_valid, .refill_vpn, .refill_ppn
    );

    ls_pipe #(.valen(valen), .palen(palen)) ls_pipe_i (
        .core_clk, .core_reset_n, .grant_valid, .grant_req, .pipe_ready, .lookup_vpn,
        .hit (tlb_hit),
        .ppn (tlb_ppn),
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_o, .wb_dat_i, .wb_ack, .wb_err,
        .ack_valid (pipe_ack_valid),
        .ack
    );

endmodule

//--- design/ls_pipe.sv
// Single-access load/store pipe with TLB translation and a Wishbone classic master
`timescale 1ns/10ps

module ls_pipe #(
    parameter int valen = 32,
    parameter int palen = 32
) (
    input  logic                              core_clk,
    input  logic                              core_reset_n,
    input  logic                              grant_valid,
    input  lsu_pkg::lsu_req_t                 grant_req,
    output logic                              pipe_ready,
    output logic [valen-1:lsu_pkg::page_bits] lookup_vpn,
    input  logic                              hit,
    input  logic [palen-1:lsu_pkg::page_bits] ppn,
    output logic                              wb_cyc,
    output logic                              wb_stb,
    output logic                              wb_we,
    output logic [palen-1:0]                  wb_adr,
    output logic [31:0]                       wb_dat_o,
    input  logic [31:0]                       wb_dat_i,
    input  logic                              wb_ack,
    input  logic                              wb_err,
    output logic                              ack_valid,
    output lsu_pkg::lsu_ack_t                 ack
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {idle, xlate, bus, resp} pipe_state_e;

    pipe_state_e      state_q;
    pipe_state_e      state_d;
    lsu_req_t         req_q;
    logic [palen-1:0] pa_q;
    logic [palen-1:0] pa_xlate;
    logic [31:0]      rdata_q;
    logic             miss_q;
    logic             err_q;
    logic             is_ptw;
    logic             is_read;
    logic             xlate_miss;
    logic             xlate_bus;
    logic             bus_done;

    assign is_ptw     = (req_q.op == op_ptw_read);
    assign is_read    = (req_q.op == op_load) || is_ptw;
    assign lookup_vpn = req_q.addr[valen-1:page_bits];
    assign pa_xlate   = is_ptw ? req_q.addr[palen-1:0] : {ppn, req_q.addr[page_bits-1:0]};
    assign xlate_miss = !is_ptw && !hit;
    assign xlate_bus  = !xlate_miss && (req_q.op != op_prefetch);  // Prefetch only translates
    assign bus_done   = wb_ack || wb_err;

    ////////////////////////////////////////
    // Wishbone master
    ////////////////////////////////////////

    assign wb_cyc   = ((state_q == xlate) && xlate_bus) || (state_q == bus);
    assign wb_stb   = wb_cyc;
    assign wb_we    = (req_q.op == op_store);
    assign wb_adr   = (state_q == bus) ? pa_q : pa_xlate;
    assign wb_dat_o = req_q.wdata;

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle:    if (grant_valid) state_d = xlate;
            xlate:   state_d = (xlate_bus && !bus_done) ? bus : resp;
            bus:     if (bus_done) state_d = resp;
            default: state_d = idle;  // resp
        endcase
    end

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            state_q <= idle;
            miss_q  <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == xlate) begin
                miss_q <= xlate_miss;
                err_q  <= wb_cyc && wb_err;
            end else if ((state_q == bus) && bus_done) begin
                err_q <= wb_err;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if ((state_q == idle) && grant_valid) begin
            req_q <= grant_req;
        end
        if (state_q == xlate) begin
            pa_q <= pa_xlate;
        end
        if (wb_cyc && bus_done) begin
            rdata_q <= wb_dat_i;
        end
    end

    ////////////////////////////////////////
    // Acknowledge
    ////////////////////////////////////////

    assign pipe_ready = (state_q == idle);
    assign ack_valid  = (state_q == resp);

    always_comb begin
        ack.src      = req_q.src;
        ack.rdata    = (is_read && !miss_q) ? rdata_q : 32'h0;
        ack.va       = req_q.addr;
        ack.tlb_miss = miss_q;
        ack.bus_err  = err_q;
    end

endmodule

//--- design/lsu_dtlb.sv
// Fully associative data TLB with combinational lookup and round-robin refill
`timescale 1ns/10ps

module lsu_dtlb #(
    parameter int valen       = 32,
    parameter int palen       = 32,
    parameter int tlb_entries = 4
) (
    input  logic                           core_clk,
    input  logic                           core_reset_n,
    input  logic [valen-1:lsu_pkg::page_bits] lookup_vpn,
    output logic                           hit,
    output logic [palen-1:lsu_pkg::page_bits] ppn,
    input  logic                           refill_valid,
    input  logic [valen-1:lsu_pkg::page_bits] refill_vpn,
    input  logic [palen-1:lsu_pkg::page_bits] refill_ppn
);
    import lsu_pkg::*;

    localparam int ptr_w = (tlb_entries > 1) ? $clog2(tlb_entries) : 1;

    logic [tlb_entries-1:0]  valid_q;
    logic [valen-1:page_bits] vpn_q [tlb_entries];
    logic [palen-1:page_bits] ppn_q [tlb_entries];
    logic [ptr_w-1:0]        victim_q;  // Next entry to replace
    logic [ptr_w-1:0]        refill_idx;
    logic                    refill_found;

    always_comb begin
        hit = 1'b0;
        ppn = '0;
        for (int i = 0; i < tlb_entries; i++) begin
            if (valid_q[i] && (vpn_q[i] == lookup_vpn)) begin
                hit = 1'b1;
                ppn = ppn | ppn_q[i];  // At most one match
            end
        end
    end

    // Refill in place when the page is already present
    always_comb begin
        refill_found = 1'b0;
        refill_idx   = victim_q;
        for (int i = 0; i < tlb_entries; i++) begin
            if (valid_q[i] && (vpn_q[i] == refill_vpn)) begin
                refill_found = 1'b1;
                refill_idx   = ptr_w'(i);
            end
        end
    end

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            valid_q  <= '0;
            victim_q <= '0;
        end else if (refill_valid) begin
            valid_q[refill_idx] <= 1'b1;
            if (!refill_found) begin
                victim_q <= (victim_q == ptr_w'(tlb_entries - 1)) ? '0 : victim_q + 1'b1;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (refill_valid) begin
            vpn_q[refill_idx] <= refill_vpn;
            ppn_q[refill_idx] <= refill_ppn;
        end
    end

endmodule

//--- design/lsu_arb.sv
// Fixed-priority requester arbiter with ack routing and MMU miss tracking
`timescale 1ns/10ps

module lsu_arb (
    input  logic               core_clk,
    input  logic               core_reset_n,
    // Page-table walker
    input  logic               dptw_valid,
    input  lsu_pkg::lsu_req_t  dptw_req,
    output logic               dptw_ready,
    // Prefetcher
    input  logic               prf_valid,
    input  lsu_pkg::lsu_req_t  prf_req,
    output logic               prf_ready,
    // Load/store queue
    input  logic               lsq_valid,
    input  lsu_pkg::lsu_req_t  lsq_req,
    output logic               lsq_ready,
    // Pipe side
    output logic               grant_valid,
    output lsu_pkg::lsu_req_t  grant_req,
    input  logic               pipe_ready,
    input  logic               pipe_ack_valid,
    input  lsu_pkg::lsu_ack_t  pipe_ack,
    output logic               dptw_ack_valid,
    output logic               prf_ack_valid,
    output logic               lsq_ack_valid,
    // MMU
    output logic               mmu_req_valid,
    output logic [31:0]        mmu_va,
    input  logic               mmu_resp_valid
);
    import lsu_pkg::*;

    logic     miss_q;  // MMU request outstanding
    logic     prf_elig;
    logic     lsq_elig;
    lsu_src_e grant_src;

    ////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////

    assign prf_elig = prf_valid && !miss_q;  // Held off during a miss
    assign lsq_elig = lsq_valid && !miss_q;

    always_comb begin
        grant_src = src_dptw;
        grant_req = dptw_req;
        if (dptw_valid) begin
            grant_src = src_dptw;
            grant_req = dptw_req;
        end else if (prf_elig) begin
            grant_src = src_prf;
            grant_req = prf_req;
        end else if (lsq_elig) begin
            grant_src = src_lsq;
            grant_req = lsq_req;
        end
        grant_req.src = grant_src;  // Ack routing follows the grant
    end

    assign grant_valid = dptw_valid || prf_elig || lsq_elig;

    assign dptw_ready = grant_valid && (grant_src == src_dptw) && pipe_ready;
    assign prf_ready  = grant_valid && (grant_src == src_prf) && pipe_ready;
    assign lsq_ready  = grant_valid && (grant_src == src_lsq) && pipe_ready;

    ////////////////////////////////////////
    // Ack routing
    ////////////////////////////////////////

    assign dptw_ack_valid = pipe_ack_valid && (pipe_ack.src == src_dptw);
    assign prf_ack_valid  = pipe_ack_valid && (pipe_ack.src == src_prf);
    assign lsq_ack_valid  = pipe_ack_valid && (pipe_ack.src == src_lsq);

    ////////////////////////////////////////
    // MMU miss tracking
    ////////////////////////////////////////

    // Only the first miss is forwarded, later ones wait for the refill
    assign mmu_req_valid = pipe_ack_valid && pipe_ack.tlb_miss && !miss_q;
    assign mmu_va        = pipe_ack.va;

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            miss_q <= 1'b0;
        end else if (mmu_resp_valid) begin
            miss_q <= 1'b0;  // Response wins
        end else if (mmu_req_valid) begin
            miss_q <= 1'b1;
        end
    end

endmodule

//--- design/lsu_pkg.sv
// Request and acknowledge types, opcode and source enums, page constant for the LSU front end
package lsu_pkg;

    localparam int page_bits = 12;  // 4 KiB pages

    ////////////////////////////////////////
    // Enums
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        op_load,
        op_store,
        op_prefetch,
        op_ptw_read  // Physical read without translation
    } lsu_op_e;

    typedef enum logic [1:0] {
        src_dptw,
        src_prf,
        src_lsq
    } lsu_src_e;

    ////////////////////////////////////////
    // Request and acknowledge
    ////////////////////////////////////////

    typedef struct packed {
        lsu_op_e     op;
        lsu_src_e    src;
        logic [31:0] addr;  // VA, or PA for the walker
        logic [31:0] wdata;
    } lsu_req_t;

    typedef struct packed {
        lsu_src_e    src;
        logic [31:0] rdata;
        logic [31:0] va;  // Request address
        logic        tlb_miss;
        logic        bus_err;
    } lsu_ack_t;

endpackage
